// ==== bench/memModels.sv ====
//==================================================
// bench memory models
// instruction rom and data ram for the mips core
//==================================================
`timescale 1ns/1ps

module instrRom (
  input  logic [31:0] addr,
  output logic [31:0] data
);

  logic [31:0] mem [0:63]; // program loaded by the testbench

  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = '0; // decodes as sll r0,r0,0
    end
  end

  assign data = mem[addr[7:2]]; // word index, combinational

endmodule

module dataRam (
  input  logic              clk,
  input  mipsPkg::dmemReq_s req,
  output logic [31:0]       rdata
);

  logic [31:0] mem [0:127]; // preloaded by the testbench

  // read only while selected and output enabled
  assign rdata = (!req.cen && !req.oen) ? mem[req.addr] : '0;

  always @(posedge clk) begin
    if (!req.cen && !req.wen)
      mem[req.addr] <= req.wdata; // store lands at the edge
  end

endmodule

// ==== bench/singleCycleMipsTb.sv ====
//==================================================
// testbench for the single cycle mips core
// program table, isa mirror and per-step checks
//==================================================
`timescale 1ns/1ps

module singleCycleMipsTb;
  import mipsPkg::*;

  localparam int clkPeriod   = 100;
  localparam int sampleDelay = clkPeriod / 4; // settle time after falling edge
  localparam int numSteps    = 24;
  localparam int waitLimit   = 16;

  // one row of the expectation table
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] addr;   // expected instrAddr
    logic        wbValid;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        load;
    logic        store;
    logic [6:0]  stAddr;
    logic [31:0] stData;
  } stepExp_s;

  logic        clk;
  logic        rst;
  logic [31:0] instr;
  logic [31:0] instrAddr;
  logic [31:0] dmemReadData;
  dmemReq_s    dmem;
  wbObs_s      wb;

  logic [31:0] progMem [0:63];
  logic [31:0] ramMirror [0:127];
  logic [31:0] regMirror [0:31];
  stepExp_s    expTable [0:numSteps-1];
  logic [31:0] endAddr;  // address of the closing self-jump
  integer      seed;
  int          errors;

  singleCycleMips singleCycleMips_inst (
    .clk          (clk),
    .rst          (rst),
    .instr        (instr),
    .instrAddr    (instrAddr),
    .dmemReadData (dmemReadData),
    .dmem         (dmem),
    .wb           (wb)
  );

  instrRom romInst (.addr(instrAddr), .data(instr));
  dataRam  ramInst (.clk(clk), .req(dmem), .rdata(dmemReadData));

  always #(clkPeriod / 2) clk = ~clk;

  //==================================================
  // instruction encoders
  function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
      input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
    return {opR, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] idx);
    return {op, idx};
  endfunction

  // flow: 0..16, 20, 30, 31, 21, 17, 23, 24, then 25 spins
  task automatic buildProgram();
    for (int i = 0; i < 64; i++) begin
      progMem[i] = '0;
    end
    progMem[0]  = encI(opLw, 0, 1, 16'd0);      // random words into r1, r2
    progMem[1]  = encI(opLw, 0, 2, 16'd4);
    progMem[2]  = encR(1, 2, 3, 0, fnAdd);
    progMem[3]  = encR(1, 2, 4, 0, fnSub);
    progMem[4]  = encR(1, 2, 5, 0, fnAnd);
    progMem[5]  = encR(1, 2, 6, 0, fnOr);
    progMem[6]  = encR(0, 1, 8, 0, fnSub);      // r8 = -r1, one side negative
    progMem[7]  = encR(8, 1, 7, 0, fnSlt);
    progMem[8]  = encR(1, 8, 9, 0, fnSlt);
    progMem[9]  = encR(1, 2, 0, 0, fnAdd);      // aimed at r0, hidden
    progMem[10] = encR(0, 0, 10, 0, fnOr);      // r0 still reads 0
    progMem[11] = encR(0, 1, 11, 4, fnSll);
    progMem[12] = encR(0, 1, 12, 7, fnSrl);
    progMem[13] = encI(opSw, 0, 3, 16'd40);
    progMem[14] = encI(opLw, 0, 13, 16'd40);    // read back the store
    progMem[15] = encI(opBeq, 1, 2, 16'd5);     // not taken
    progMem[16] = encI(opBeq, 0, 0, 16'd3);     // taken forward to 20
    progMem[17] = encJ(opJ, 26'd23);
    progMem[20] = encJ(opJal, 26'd30);
    progMem[21] = encI(opBeq, 10, 0, 16'hfffb); // back 5 words to 17
    progMem[23] = encI(opSw, 31, 6, 16'hfff8);  // link minus 8
    progMem[24] = encI(opLw, 31, 14, 16'hfffc);
    progMem[25] = encJ(opJ, 26'd25);            // self-jump
    progMem[30] = encR(3, 6, 15, 0, fnAdd);     // subroutine body
    progMem[31] = encR(31, 0, 0, 0, fnJr);
  endtask

  //==================================================
  // isa mirror, one instruction per call
  task automatic predictStep(input int k, inout logic [31:0] pc);
    logic [31:0] w;
    logic [31:0] rsV;
    logic [31:0] rtV;
    logic [31:0] imm;
    logic [31:0] ea;
    logic [31:0] res;
    logic [31:0] nextPc;
    logic [4:0]  dest;
    logic        wr;
    stepExp_s    e;
    w      = progMem[pc[7:2]];
    rsV    = regMirror[w[25:21]];
    rtV    = regMirror[w[20:16]];
    imm    = {{16{w[15]}}, w[15:0]};
    ea     = rsV + imm;           // base plus offset
    nextPc = pc + 32'd4;
    dest   = w[15:11];
    wr     = 1'b0;
    res    = '0;
    e      = '0;
    e.instr = w;
    e.addr  = pc;
    case (w[31:26])
      opR: begin
        wr = 1'b1;
        case (w[5:0])
          fnAdd: res = rsV + rtV;
          fnSub: res = rsV - rtV;
          fnAnd: res = rsV & rtV;
          fnOr:  res = rsV | rtV;
          fnSlt: res = ($signed(rsV) < $signed(rtV)) ? 32'd1 : 32'd0;
          fnSll: res = rtV << w[10:6];
          fnSrl: res = rtV >> w[10:6];
          fnJr: begin
            wr     = 1'b0;
            nextPc = rsV;
          end
          default: wr = 1'b0;
        endcase
      end
      opLw: begin
        wr     = 1'b1;
        dest   = w[20:16];
        res    = ramMirror[ea[8:2]];
        e.load = 1'b1;
      end
      opSw: begin
        e.store             = 1'b1;
        e.stAddr            = ea[8:2];
        e.stData            = rtV;
        ramMirror[ea[8:2]]  = rtV;
      end
      opBeq: begin
        if (rsV == rtV)
          nextPc = pc + 32'd4 + {imm[29:0], 2'b00};
      end
      opJ: nextPc = {nextPc[31:28], w[25:0], 2'b00};
      opJal: begin
        wr     = 1'b1;
        dest   = 5'd31;
        res    = pc + 32'd4; // no delay slot
        nextPc = {nextPc[31:28], w[25:0], 2'b00};
      end
      default: wr = 1'b0;
    endcase
    if (wr && dest != 5'd0) begin
      e.wbValid       = 1'b1;
      e.wbAddr        = dest;
      e.wbData        = res;
      regMirror[dest] = res;
    end
    expTable[k] = e;
    pc = nextPc;
  endtask

  //==================================================
  // checks
  task automatic checkValue(input string name, input logic [31:0] actual,
      input logic [31:0] expected);
    assert (actual === expected)
    else begin
      errors++;
      $display("** Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
      $display("Verification failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic checkStep(input stepExp_s e);
    checkValue("instr", instr, e.instr);
    checkValue("instrAddr", instrAddr, e.addr);
    checkValue("wb.valid", wb.valid, e.wbValid);
    if (e.wbValid) begin
      checkValue("wb.addr", wb.addr, e.wbAddr);
      checkValue("wb.data", wb.data, e.wbData);
    end
    checkValue("dmem.cen", dmem.cen, !(e.load || e.store));
    checkValue("dmem.wen", dmem.wen, !e.store);
    checkValue("dmem.oen", dmem.oen, !e.load);
    if (e.store) begin
      checkValue("dmem.addr", dmem.addr, e.stAddr);
      checkValue("dmem.wdata", dmem.wdata, e.stData);
    end
  endtask

  initial begin
    logic [31:0] pc;
    int          cycles;
    clk    = 1'b0;
    rst    = 1'b1;
    errors = 0;
    seed   = 44;
    buildProgram();
    for (int i = 0; i < 128; i++) begin
      ramMirror[i]   = $random(seed);
      ramInst.mem[i] = ramMirror[i];
    end
    for (int i = 0; i < 32; i++) begin
      regMirror[i] = '0;
    end
    pc = '0;
    for (int k = 0; k < numSteps; k++) begin
      predictStep(k, pc);
    end
    endAddr = pc;

    // reset phase, rom still empty
    repeat (9) @(negedge clk);
    #(sampleDelay);
    checkValue("instrAddr", instrAddr, 32'd0);
    checkValue("wb.valid", wb.valid, 1'b0);
    checkValue("dmem.cen", dmem.cen, 1'b1);
    checkValue("dmem.wen", dmem.wen, 1'b1);
    checkValue("dmem.oen", dmem.oen, 1'b1);
    @(negedge clk);
    for (int i = 0; i < 64; i++) begin
      romInst.mem[i] = progMem[i];
    end
    rst = 1'b0; // tenth falling edge

    for (int k = 0; k < numSteps; k++) begin
      #(sampleDelay);
      checkStep(expTable[k]);
      @(negedge clk);
    end

    // bounded wait for the closing self-jump
    cycles = 0;
    #(sampleDelay);
    while (instrAddr !== endAddr && cycles < waitLimit) begin
      @(negedge clk);
      #(sampleDelay);
      cycles++;
    end
    if (instrAddr !== endAddr) begin
      $display("timeout: core never reached the final self-jump");
      $display("Verification failed");
      $fatal(1, "timeout waiting for the self-jump");
    end
    @(negedge clk);
    #(sampleDelay);
    checkValue("instrAddr", instrAddr, endAddr); // spin holds
    checkValue("wb.valid", wb.valid, 1'b0);

    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== singleCycleMips.f ====
verilog/mipsPkg.sv
verilog/programCounter.sv
verilog/controlDecoder.sv
verilog/regFile.sv
verilog/alu.sv
verilog/singleCycleMips.sv
bench/memModels.sv
bench/singleCycleMipsTb.sv

// ==== verilog/alu.sv ====
//==================================================
// alu
// add, sub, logic, signed compare and shifts
//==================================================
`timescale 1ns/1ps

module alu (
  input  logic            [31:0] opA,
  input  logic            [31:0] opB,
  input  mipsPkg::aluOp_e        op,
  output logic            [31:0] result,
  output logic                   zero
);
  import mipsPkg::*;

  logic [4:0] shiftAmt;

  assign shiftAmt = opA[4:0]; // shamt or rs low bits

  always_comb begin
    case (op)
      aluAdd: result = opA + opB; // no overflow trap
      aluSub: result = opA - opB;
      aluAnd: result = opA & opB;
      aluOr:  result = opA | opB;

      aluSlt: begin
        if ($signed(opA) < $signed(opB))
          result = 32'd1;
        else
          result = 32'd0;
      end

      // shifted value comes in on opB
      aluSll: result = opB << shiftAmt;
      aluSrl: result = opB >> shiftAmt; // logical, zero fill

      default: begin
        result = '0; // aluNone
      end
    endcase
  end

  // valid for every op
  // beq only looks at it after aluSub
  assign zero = (result == '0);

endmodule

// ==== verilog/controlDecoder.sv ====
//==================================================
// control decoder
// main decode of opcode plus alu control from funct
//==================================================
`timescale 1ns/1ps

module controlDecoder (
  input  logic [5:0]     op,
  input  logic [5:0]     funct,
  output mipsPkg::ctrl_s ctrl
);
  import mipsPkg::*;

  always_comb begin
    ctrl       = '0;      // unknown op writes nothing
    ctrl.aluOp = aluNone;

    case (op)
      opR: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct) // alu control merged in here
          fnAdd: ctrl.aluOp = aluAdd;
          fnSub: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr:  ctrl.aluOp = aluOr;
          fnSlt: ctrl.aluOp = aluSlt;
          fnSll: begin
            ctrl.aluOp    = aluSll;
            ctrl.shiftSrc = 1'b1; // shamt into operand a
          end
          fnSrl: begin
            ctrl.aluOp    = aluSrl;
            ctrl.shiftSrc = 1'b1;
          end
          fnJr: begin
            ctrl.jumpReg  = 1'b1;
            ctrl.regWrite = 1'b0; // jr has no result
          end
          default: begin
            ctrl.regWrite = 1'b0; // unsupported funct
          end
        endcase
      end

      // address = base + offset
      opLw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.memRead  = 1'b1;
        ctrl.aluOp    = aluAdd;
      end

      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
        ctrl.aluOp    = aluAdd;
      end

      opBeq: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = aluSub; // zero flag means equal
      end

      opJ: begin
        ctrl.jump = 1'b1;
      end

      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1; // pc+4 into r31
        ctrl.regWrite = 1'b1;
      end

      default: begin
        ctrl.regWrite = 1'b0;
        ctrl.memWrite = 1'b0;
      end
    endcase
  end

endmodule

// ==== verilog/mipsPkg.sv ====
//==================================================
// mips core package
// opcodes, function codes, alu ops and datapath bundles
//==================================================
package mipsPkg;

  //==================================================
  // primary opcodes, bits 31..26
  localparam logic [5:0] opR   = 6'b000000; // r-type, funct picks the op
  localparam logic [5:0] opLw  = 6'b100011;
  localparam logic [5:0] opSw  = 6'b101011;
  localparam logic [5:0] opBeq = 6'b000100;
  localparam logic [5:0] opJ   = 6'b000010;
  localparam logic [5:0] opJal = 6'b000011;

  // r-type function codes, bits 5..0
  localparam logic [5:0] fnAdd = 6'b100000;
  localparam logic [5:0] fnSub = 6'b100010;
  localparam logic [5:0] fnAnd = 6'b100100;
  localparam logic [5:0] fnOr  = 6'b100101;
  localparam logic [5:0] fnSlt = 6'b101010;
  localparam logic [5:0] fnSll = 6'b000000;
  localparam logic [5:0] fnSrl = 6'b000010;
  localparam logic [5:0] fnJr  = 6'b001000;

  localparam logic [4:0] regLink   = 5'd31; // jal return address
  localparam int         dmemAddrW = 7;     // data ram word address bits

  // alu operation select
  typedef enum logic [3:0] {
    aluAdd  = 4'd0,
    aluSub  = 4'd1,
    aluAnd  = 4'd2,
    aluOr   = 4'd3,
    aluSlt  = 4'd4, // signed compare
    aluSll  = 4'd5,
    aluSrl  = 4'd6,
    aluNone = 4'd15 // illegal or no alu use
  } aluOp_e;

  //==================================================
  // instruction word views
  typedef struct packed {
    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFmt_s;

  typedef struct packed {
    logic [5:0]  op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16; // offset for lw, sw and beq
  } iFmt_s;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target26;
  } jFmt_s;

  typedef union packed {
    rFmt_s r;
    iFmt_s i;
    jFmt_s j;
  } instrWord_u;

  // decoded datapath controls
  typedef struct packed {
    logic   regDst;   // write rd instead of rt
    logic   aluSrc;   // operand b from imm16
    logic   memToReg;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    logic   branch;
    logic   jump;
    logic   jumpReg;  // jr
    logic   link;     // jal writes pc+4
    logic   shiftSrc; // operand a from shamt
    aluOp_e aluOp;
  } ctrl_s;

  //==================================================
  // external port bundles
  typedef struct packed {
    logic                 cen; // all three strobes active low
    logic                 wen;
    logic                 oen;
    logic [dmemAddrW-1:0] addr;
    logic [31:0]          wdata;
  } dmemReq_s;

  typedef struct packed {
    logic        valid;
    logic [4:0]  addr;
    logic [31:0] data;
  } wbObs_s;

endpackage

// ==== verilog/programCounter.sv ====
//==================================================
// program counter
// pc register and next address select
//==================================================
`timescale 1ns/1ps

module programCounter (
  input  logic           clk,
  input  logic           rst,
  input  mipsPkg::ctrl_s ctrl,
  input  logic           aluZero,
  input  logic [31:0]    branchOffset, // sign extended imm16
  input  logic [25:0]    target26,
  input  logic [31:0]    jumpTarget,   // rs data for jr
  output logic [31:0]    pc,
  output logic [31:0]    pcPlus4
);

  logic [31:0] pcNext;
  logic [31:0] branchAddr;
  logic [31:0] jumpAddr;
  logic        takeBranch;

  assign pcPlus4    = pc + 32'd4;
  assign branchAddr = pcPlus4 + {branchOffset[29:0], 2'b00}; // offset in words
  assign jumpAddr   = {pcPlus4[31:28], target26, 2'b00};    // same 256MB region
  assign takeBranch = ctrl.branch & aluZero;                 // beq, rs == rt

  // jr beats j beats a taken beq
  always_comb begin
    if (ctrl.jumpReg)
      pcNext = jumpTarget;
    else if (ctrl.jump)
      pcNext = jumpAddr;
    else if (takeBranch)
      pcNext = branchAddr;
    else
      pcNext = pcPlus4;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      pc <= '0;
    else
      pc <= pcNext; // one instruction per cycle
  end

  // instruction fetch needs a word address every cycle
  pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("pc lost word alignment");

endmodule

// ==== verilog/regFile.sv ====
//==================================================
// register file
// 31 general registers with r0 reading as zero
//==================================================
`timescale 1ns/1ps

module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic        writeEn,
  input  logic [4:0]  writeAddr,
  input  logic [31:0] writeData,
  input  logic [4:0]  readAddr1,
  input  logic [4:0]  readAddr2,
  output logic [31:0] readData1,
  output logic [31:0] readData2
);

  logic [31:0] regs [1:31]; // no storage behind r0

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != 5'd0)) begin
      regs[writeAddr] <= writeData; // r0 writes dropped
    end
  end

  // combinational reads
  // a same-cycle write shows up next cycle only
  assign readData1 = (readAddr1 == 5'd0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == 5'd0) ? '0 : regs[readAddr2];

endmodule

// ==== verilog/singleCycleMips.sv ====
//==================================================
// single cycle mips core
// fetch, decode, execute and write back in one clock
//==================================================
`timescale 1ns/1ps

module singleCycleMips (
  input  logic              clk,
  input  logic              rst,
  input  logic [31:0]       instr,
  output logic [31:0]       instrAddr,
  input  logic [31:0]       dmemReadData,
  output mipsPkg::dmemReq_s dmem,
  output mipsPkg::wbObs_s   wb
);
  import mipsPkg::*;

  instrWord_u  iw;        // one word seen three ways
  ctrl_s       ctrl;
  logic [31:0] pc;
  logic [31:0] pcPlus4;
  logic [31:0] immExt;
  logic [4:0]  writeAddr;
  logic [31:0] writeData;
  logic [31:0] rsData;
  logic [31:0] rtData;
  logic [31:0] aluA;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic        aluZero;

  assign iw        = instrWord_u'(instr);
  assign instrAddr = pc; // fetch from current pc
  assign immExt    = {{16{iw.i.imm16[15]}}, iw.i.imm16};

  //==================================================
  // decode and register read
  controlDecoder controlDecoderInst (
    .op    (iw.r.op),
    .funct (iw.r.funct),
    .ctrl  (ctrl)
  );

  // rd for r-type, r31 for jal, rt for lw
  always_comb begin
    if (ctrl.regDst)
      writeAddr = iw.r.rd;
    else if (ctrl.link)
      writeAddr = regLink;
    else
      writeAddr = iw.i.rt;
  end

  regFile regFileInst (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (ctrl.regWrite),
    .writeAddr (writeAddr),
    .writeData (writeData),
    .readAddr1 (iw.r.rs),
    .readAddr2 (iw.r.rt),
    .readData1 (rsData),
    .readData2 (rtData)
  );

  //==================================================
  // execute
  assign aluA = ctrl.shiftSrc ? {27'd0, iw.r.shamt} : rsData; // shift amount
  assign aluB = ctrl.aluSrc ? immExt : rtData;

  alu aluInst (
    .opA    (aluA),
    .opB    (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  programCounter programCounterInst (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .aluZero      (aluZero),
    .branchOffset (immExt),
    .target26     (iw.j.target26),
    .jumpTarget   (rsData),
    .pc           (pc),
    .pcPlus4      (pcPlus4)
  );

  //==================================================
  // data port and write back
  always_comb begin
    dmem.cen   = ~(ctrl.memRead | ctrl.memWrite);
    dmem.wen   = ~ctrl.memWrite; // ram writes at next edge
    dmem.oen   = ~ctrl.memRead;
    dmem.addr  = aluResult[8:2]; // byte address to word
    dmem.wdata = rtData;
  end

  // load data, then link address, then alu
  always_comb begin
    if (ctrl.memToReg)
      writeData = dmemReadData;
    else if (ctrl.link)
      writeData = pcPlus4; // no delay slot
    else
      writeData = aluResult;
  end

  always_comb begin
    wb.valid = ctrl.regWrite && (writeAddr != 5'd0); // r0 writes hidden
    wb.addr  = writeAddr;
    wb.data  = writeData;
  end

  // a store never opens the ram output
  storeNoRead: assert property (@(posedge clk) disable iff (rst)
    !dmem.wen |-> dmem.oen)
    else $error("data write strobe and output enable low together");

endmodule
